/* logic/acc_cpu_pkg.sv */
`default_nettype none

package acc_cpu_pkg;

    // data path width and default address width
    localparam int WORD_W     = 16;
    localparam int DEF_ADDR_W = 10;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [DEF_ADDR_W-1:0] addr_t;

    // alu function codes
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_MUL  = 4'd2,
        ALU_DIV  = 4'd3,
        ALU_SHL  = 4'd4,
        ALU_SHR  = 4'd5,
        ALU_ROL  = 4'd6,
        ALU_ROR  = 4'd7,
        ALU_AND  = 4'd8,
        ALU_OR   = 4'd9,
        ALU_XOR  = 4'd10,
        ALU_NOR  = 4'd11,
        ALU_NAND = 4'd12,
        ALU_XNOR = 4'd13,
        ALU_GT   = 4'd14,
        ALU_EQ   = 4'd15
    } alu_func_t;

    // instruction class in bits 15..14
    typedef enum logic [1:0] {
        CLS_ALU  = 2'd0,
        CLS_LDA  = 2'd1,
        CLS_STA  = 2'd2,
        CLS_CTRL = 2'd3
    } instr_class_t;

    // jump kind in bits 13..10 for the control class where other codes are no-ops
    typedef enum logic [3:0] {
        CTL_JMP  = 4'd0,
        CTL_JZ   = 4'd1,
        CTL_HALT = 4'd2
    } ctrl_kind_t;

    // one instruction word with class, function or kind and word address
    typedef struct packed {
        instr_class_t cls;
        logic [3:0]   fn;
        addr_t        adr;
    } instr_t;

    // wishbone classic request from master to slave
    typedef struct packed {
        logic  cyc;
        logic  stb;
        logic  we;
        addr_t adr;
        word_t dat;
    } wb_req_t;

    // wishbone classic response from slave to master
    typedef struct packed {
        logic  ack;
        word_t dat;
    } wb_rsp_t;

    // load enables from sequencer to datapath
    typedef struct packed {
        logic ld_ir;
        logic ld_mbr;
        logic ld_mar_operand;
        logic ld_acc_alu;
        logic ld_acc_mem;
        logic pc_inc;
        logic pc_jump;
        logic pc_clear;
    } seq_ctrl_t;

    // decoded fields back to the sequencer
    typedef struct packed {
        instr_class_t cls;
        ctrl_kind_t   kind;
        logic         acc_zero;
    } dp_status_t;

endpackage

`default_nettype wire

/* logic/alu.sv */
`default_nettype none

module alu
    import acc_cpu_pkg::*;
(
    input  alu_func_t func,
    input  word_t     a,
    input  word_t     b,
    output word_t     y
);

    // b only matters for the two-operand functions
    always_comb begin
        case (func)
            ALU_ADD: y = a + b;
            ALU_SUB: y = a - b;
            // low half of the product
            ALU_MUL: y = a * b;
            ALU_DIV: begin
                // divide by zero gives all ones
                if (b == '0) begin
                    y = '1;
                end else begin
                    y = a / b;
                end
            end
            // logical shifts by one
            ALU_SHL: y = {a[WORD_W-2:0], 1'b0};
            ALU_SHR: y = {1'b0, a[WORD_W-1:1]};
            // rotates by one
            ALU_ROL: y = {a[WORD_W-2:0], a[WORD_W-1]};
            ALU_ROR: y = {a[0], a[WORD_W-1:1]};
            ALU_AND: y = a & b;
            ALU_OR: y = a | b;
            ALU_XOR: y = a ^ b;
            ALU_NOR: y = ~(a | b);
            ALU_NAND: y = ~(a & b);
            ALU_XNOR: y = ~(a ^ b);
            // unsigned compare, result is one or zero
            ALU_GT: begin
                if (a > b) begin
                    y = word_t'(1);
                end else begin
                    y = '0;
                end
            end
            ALU_EQ: begin
                if (a == b) begin
                    y = word_t'(1);
                end else begin
                    y = '0;
                end
            end
            default: y = '0;
        endcase
    end

endmodule

`default_nettype wire

/* logic/cpu_datapath.sv */
`default_nettype none

module cpu_datapath
    import acc_cpu_pkg::*;
#(
    parameter int ADDR_W = DEF_ADDR_W
) (
    input  wire        clk,
    input  wire        arst_n,
    input  seq_ctrl_t  ctrl,
    input  word_t      mem_dat,
    output dp_status_t status,
    output addr_t      mar,
    output word_t      acc,
    output addr_t      pc
);

    typedef logic [ADDR_W-1:0] pc_t;

    pc_t    pc_q;
    pc_t    pc_d;
    pc_t    mar_q;
    pc_t    mar_d;
    pc_t    op_adr;
    instr_t ir_q;
    word_t  mbr_q;
    word_t  acc_q;
    word_t  alu_y;

    // address field of the current instruction, sized to memory depth
    assign op_adr = pc_t'(ir_q.adr);

    // next pc, clear beats jump beats increment
    always_comb begin
        pc_d = pc_q;
        if (ctrl.pc_clear) begin
            pc_d = '0;
        end else if (ctrl.pc_jump) begin
            pc_d = op_adr;
        end else if (ctrl.pc_inc) begin
            // wraps at the top of memory
            pc_d = pc_q + 1'b1;
        end
    end

    // mar follows the pc unless the operand address is selected
    // so it is already pointing at the next fetch after exec
    assign mar_d = ctrl.ld_mar_operand ? op_adr : pc_d;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc_q  <= '0;
            mar_q <= '0;
            ir_q  <= '0;
            mbr_q <= '0;
            acc_q <= '0;
        end else begin
            pc_q  <= pc_d;
            mar_q <= mar_d;
            if (ctrl.ld_ir) begin
                ir_q <= instr_t'(mem_dat);
            end
            if (ctrl.ld_mbr) begin
                mbr_q <= mem_dat;
            end
            // a new run starts from a clean accumulator
            if (ctrl.pc_clear) begin
                acc_q <= '0;
            end else if (ctrl.ld_acc_alu) begin
                acc_q <= alu_y;
            end else if (ctrl.ld_acc_mem) begin
                acc_q <= mbr_q;
            end
        end
    end

    // acc op mbr, function straight from the ir
    alu u_alu (
        .func (alu_func_t'(ir_q.fn)),
        .a    (acc_q),
        .b    (mbr_q),
        .y    (alu_y)
    );

    // decode for the sequencer
    assign status.cls      = ir_q.cls;
    assign status.kind     = ctrl_kind_t'(ir_q.fn);
    assign status.acc_zero = (acc_q == '0);

    assign mar = addr_t'(mar_q);
    assign pc  = addr_t'(pc_q);
    assign acc = acc_q;

endmodule

`default_nettype wire

/* logic/cpu_sequencer.sv */
`default_nettype none

module cpu_sequencer
    import acc_cpu_pkg::*;
(
    input  wire        clk,
    input  wire        arst_n,
    input  logic       run,
    input  dp_status_t status,
    input  wb_rsp_t    bus_rsp,
    output seq_ctrl_t  ctrl,
    output logic       cyc,
    output logic       stb,
    output logic       we,
    output logic       busy,
    output logic       halted
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_FETCH,
        ST_DECODE,
        ST_OPERAND,
        ST_STORE,
        ST_EXEC,
        ST_HALTED
    } seq_state_t;

    seq_state_t state_q;
    seq_state_t state_d;
    logic       is_halt;

    assign is_halt = (status.cls == CLS_CTRL) && (status.kind == CTL_HALT);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        ctrl    = '0;
        case (state_q)
            ST_IDLE, ST_HALTED: begin
                // start over from address zero
                if (run) begin
                    ctrl.pc_clear = 1'b1;
                    state_d       = ST_FETCH;
                end
            end
            ST_FETCH: begin
                // mar holds pc here, wait for the word
                if (bus_rsp.ack) begin
                    ctrl.ld_ir = 1'b1;
                    state_d    = ST_DECODE;
                end
            end
            ST_DECODE: begin
                ctrl.ld_mar_operand = 1'b1;
                // pc stays on a halt so it reports the halt address
                ctrl.pc_inc = !is_halt;
                case (status.cls)
                    CLS_CTRL: state_d = ST_EXEC;
                    CLS_STA: state_d = ST_STORE;
                    default: state_d = ST_OPERAND;
                endcase
            end
            ST_OPERAND: begin
                // keep operand address on the bus until ack
                ctrl.ld_mar_operand = 1'b1;
                if (bus_rsp.ack) begin
                    ctrl.ld_mbr = 1'b1;
                    state_d     = ST_EXEC;
                end
            end
            ST_STORE: begin
                ctrl.ld_mar_operand = 1'b1;
                if (bus_rsp.ack) begin
                    state_d = ST_EXEC;
                end
            end
            ST_EXEC: begin
                state_d = ST_FETCH;
                case (status.cls)
                    CLS_ALU: ctrl.ld_acc_alu = 1'b1;
                    CLS_LDA: ctrl.ld_acc_mem = 1'b1;
                    CLS_CTRL: begin
                        case (status.kind)
                            CTL_JMP: ctrl.pc_jump = 1'b1;
                            // taken only on a zero accumulator
                            CTL_JZ: ctrl.pc_jump = status.acc_zero;
                            CTL_HALT: state_d = ST_HALTED;
                            default: ctrl.pc_jump = 1'b0;
                        endcase
                    end
                    // store already done on the bus
                    default: ctrl.ld_acc_alu = 1'b0;
                endcase
            end
            default: state_d = ST_IDLE;
        endcase
    end

    // bus strobes straight from state, dropped the cycle after ack
    assign cyc    = (state_q == ST_FETCH) || (state_q == ST_OPERAND) || (state_q == ST_STORE);
    assign stb    = cyc;
    assign we     = (state_q == ST_STORE);
    assign busy   = (state_q != ST_IDLE) && (state_q != ST_HALTED);
    assign halted = (state_q == ST_HALTED);

    // wishbone rules for the master side
    a_stb_in_cyc: assert property (@(posedge clk) disable iff (!arst_n)
        stb |-> cyc);

    // request held steady while waiting on a stalled slave
    a_req_stable: assert property (@(posedge clk) disable iff (!arst_n)
        (stb && !bus_rsp.ack) |=> (stb && $stable(we)));

    a_halt_not_busy: assert property (@(posedge clk) disable iff (!arst_n)
        !(halted && busy));

endmodule

`default_nettype wire

/* logic/main_memory.sv */
`default_nettype none

module main_memory
    import acc_cpu_pkg::*;
#(
    parameter int ADDR_W = DEF_ADDR_W
) (
    input  wire     clk,
    input  wire     arst_n,
    input  wb_req_t host_req,
    output wb_rsp_t host_rsp,
    input  wb_req_t cpu_req,
    output wb_rsp_t cpu_rsp
);

    typedef logic [ADDR_W-1:0] mem_addr_t;

    word_t mem [2**ADDR_W];

    logic  host_ack_q;
    logic  cpu_ack_q;
    word_t host_rd_q;
    word_t cpu_rd_q;
    logic  host_go;
    logic  cpu_go;

    // grant once per request, not again in the ack cycle
    assign host_go = host_req.cyc && host_req.stb && !host_ack_q;
    // processor waits while the host strobes
    assign cpu_go  = cpu_req.cyc && cpu_req.stb && !cpu_ack_q
                     && !(host_req.cyc && host_req.stb);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            host_ack_q <= 1'b0;
            cpu_ack_q  <= 1'b0;
        end else begin
            host_ack_q <= host_go;
            cpu_ack_q  <= cpu_go;
        end
    end

    // array and read data, no reset; write lands on the ack edge
    always_ff @(posedge clk) begin
        if (host_go) begin
            if (host_req.we) begin
                mem[mem_addr_t'(host_req.adr)] <= host_req.dat;
            end else begin
                host_rd_q <= mem[mem_addr_t'(host_req.adr)];
            end
        end else if (cpu_go) begin
            if (cpu_req.we) begin
                mem[mem_addr_t'(cpu_req.adr)] <= cpu_req.dat;
            end else begin
                cpu_rd_q <= mem[mem_addr_t'(cpu_req.adr)];
            end
        end
    end

    assign host_rsp.ack = host_ack_q;
    assign host_rsp.dat = host_rd_q;
    assign cpu_rsp.ack  = cpu_ack_q;
    assign cpu_rsp.dat  = cpu_rd_q;

    // arbitration keeps the two ports apart
    a_one_ack: assert property (@(posedge clk) disable iff (!arst_n)
        !(host_rsp.ack && cpu_rsp.ack));

    a_host_ack_req: assert property (@(posedge clk) disable iff (!arst_n)
        host_rsp.ack |-> $past(host_req.cyc && host_req.stb));

    a_cpu_ack_req: assert property (@(posedge clk) disable iff (!arst_n)
        cpu_rsp.ack |-> $past(cpu_req.cyc && cpu_req.stb));

endmodule

`default_nettype wire

/* logic/acc_cpu_top.sv */
`default_nettype none

module acc_cpu_top
    import acc_cpu_pkg::*;
#(
    parameter int ADDR_W = DEF_ADDR_W
) (
    input  wire     clk,
    input  wire     arst_n,
    input  logic    run,
    input  wb_req_t host_req,
    output wb_rsp_t host_rsp,
    output logic    halted,
    output logic    busy,
    output word_t   acc,
    output addr_t   pc
);

    seq_ctrl_t  seq_ctrl;
    dp_status_t dp_status;
    wb_req_t    cpu_req;
    wb_rsp_t    cpu_rsp;
    addr_t      mar;

    // strobes from the sequencer, address and write data from the datapath
    assign cpu_req.adr = mar;
    assign cpu_req.dat = acc;

    cpu_sequencer u_cpu_sequencer (
        .clk    (clk),
        .arst_n (arst_n),
        .run    (run),
        .status (dp_status),
        .bus_rsp(cpu_rsp),
        .ctrl   (seq_ctrl),
        .cyc    (cpu_req.cyc),
        .stb    (cpu_req.stb),
        .we     (cpu_req.we),
        .busy   (busy),
        .halted (halted)
    );

    cpu_datapath #(.ADDR_W(ADDR_W)) u_cpu_datapath (
        .clk    (clk),
        .arst_n (arst_n),
        .ctrl   (seq_ctrl),
        .mem_dat(cpu_rsp.dat),
        .status (dp_status),
        .mar    (mar),
        .acc    (acc),
        .pc     (pc)
    );

    // host port wins on a tie
    main_memory #(.ADDR_W(ADDR_W)) u_main_memory (
        .clk     (clk),
        .arst_n  (arst_n),
        .host_req(host_req),
        .host_rsp(host_rsp),
        .cpu_req (cpu_req),
        .cpu_rsp (cpu_rsp)
    );

endmodule

`default_nettype wire

/* verification/acc_cpu_tb.sv */
`default_nettype none

module acc_cpu_tb
    import acc_cpu_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    // program tests after one plain memory test
    localparam int N_TESTS   = 24;
    localparam int MAX_INSTR = 40;
    localparam int MEM_WORDS = 1024;
    // two cycles per host access plus ten per instruction for contention
    localparam int unsigned CYCLE_LIMIT =
        (N_TESTS + 1) * (MEM_WORDS + 10 * MAX_INSTR + MEM_WORDS) * 2;

    logic    clk = 1'b0;
    logic    arst_n;
    logic    run;
    wb_req_t host_req;
    wb_rsp_t host_rsp;
    logic    halted;
    logic    busy;
    word_t   acc;
    addr_t   pc;

    logic [31:0] seed;
    int unsigned cycles = 0;
    int          error_count = 0;
    // image loaded by the host and the model's view of memory
    word_t       img [MEM_WORDS];
    word_t       model_mem [MEM_WORDS];

    acc_cpu_top #(.ADDR_W(DEF_ADDR_W)) u_acc_cpu_top (
        .clk     (clk),
        .arst_n  (arst_n),
        .run     (run),
        .host_req(host_req),
        .host_rsp(host_rsp),
        .halted  (halted),
        .busy    (busy),
        .acc     (acc),
        .pc      (pc)
    );

    always #5 clk = ~clk;

    // hard stop if the tests run too long
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timed out after %0d cycles before all tests finished", cycles);
            $display("Testbench failed");
            $fatal(1, "timeout");
        end
    end

    task automatic report_error(input string msg);
        error_count++;
        $display("[ERROR] %0d ns: %s", $time, msg);
        $display("Testbench failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            report_error($sformatf("%s: got %h, expected %h", what, got, exp));
        end
    endtask

    task automatic check_addr(input addr_t got, input addr_t exp, input string what);
        if (got !== exp) begin
            report_error($sformatf("%s: got %h, expected %h", what, got, exp));
        end
    endtask

    // lcg whose upper bits are the useful ones
    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic int rand_below(input int n);
        logic [31:0] r;
        r = next_rand();
        return int'(r[31:16]) % n;
    endfunction

    // alu model for codes 0 to 15
    function automatic word_t alu_model(input logic [3:0] fn, input word_t a, input word_t b);
        case (fn)
            4'd0: return a + b;
            4'd1: return a - b;
            4'd2: return a * b;
            // zero divisor gives all ones
            4'd3: return (b == 16'd0) ? 16'hffff : a / b;
            4'd4: return a << 1;
            4'd5: return a >> 1;
            4'd6: return (a << 1) | (a >> 15);
            4'd7: return (a >> 1) | (a << 15);
            4'd8: return a & b;
            4'd9: return a | b;
            4'd10: return a ^ b;
            4'd11: return ~(a | b);
            4'd12: return ~(a & b);
            4'd13: return ~(a ^ b);
            4'd14: return (a > b) ? 16'd1 : 16'd0;
            default: return (a == b) ? 16'd1 : 16'd0;
        endcase
    endfunction

    // one classic cycle on the host port entered and left 1 ns after an edge
    task automatic host_xfer(input logic we, input addr_t adr, input word_t dat,
                             output word_t rd);
        int waited;
        waited = 0;
        host_req.cyc = 1'b1;
        host_req.stb = 1'b1;
        host_req.we  = we;
        host_req.adr = adr;
        host_req.dat = dat;
        do begin
            @(posedge clk);
            #1;
            waited++;
        end while (!host_rsp.ack);
        if (waited != 1) begin
            report_error("host ack did not come one cycle after the request");
        end
        rd = host_rsp.dat;
        host_req = '0;
        // idle cycle between requests
        @(posedge clk);
        #1;
    endtask

    task automatic load_image();
        word_t rd;
        for (int i = 0; i < MEM_WORDS; i++) begin
            host_xfer(1'b1, addr_t'(i), img[i], rd);
        end
    endtask

    task automatic readback_all();
        word_t rd;
        for (int i = 0; i < MEM_WORDS; i++) begin
            host_xfer(1'b0, addr_t'(i), '0, rd);
            check_word(rd, model_mem[i], $sformatf("memory word %0d", i));
        end
    endtask

    // kind 0 is alu only; 1 adds loads and stores; 2 is any class; 3 is alu and loads
    task automatic build_program(input int kind);
        int           n;
        int           i;
        logic [31:0]  r;
        instr_class_t cls;
        logic [3:0]   fn;
        addr_t        adr;
        // some zero words for jz and zero divisors
        for (i = 0; i < MEM_WORDS; i++) begin
            r = next_rand();
            img[i] = (r[31:29] == 3'd0) ? '0 : r[23:8];
        end
        n = 2 + rand_below(MAX_INSTR - 1);
        for (i = 0; i < n - 1; i++) begin
            r = next_rand();
            fn = r[19:16];
            // operands always in the upper half
            adr = {1'b1, r[28:20]};
            case (kind)
                0: cls = CLS_ALU;
                1: cls = (r[31:30] == 2'd3) ? CLS_ALU : instr_class_t'(r[31:30]);
                2: cls = instr_class_t'(r[31:30]);
                default: cls = r[31] ? CLS_LDA : CLS_ALU;
            endcase
            if (cls == CLS_CTRL) begin
                // jz more often than jmp plus some no-op kinds
                case (r[15:14])
                    2'd0: fn = 4'(CTL_JMP);
                    2'd1, 2'd2: fn = 4'(CTL_JZ);
                    default: fn = 4'd3 + 4'(rand_below(13));
                endcase
                // forward only and at most onto the final halt
                adr = addr_t'(i + 1 + rand_below(n - 1 - i));
            end
            img[i] = {cls, fn, adr};
        end
        img[n - 1] = {CLS_CTRL, 4'(CTL_HALT), r[9:0]};
    endtask

    // instruction set model over model_mem
    task automatic run_model(output word_t m_acc, output addr_t m_pc);
        word_t ins;
        addr_t adr;
        addr_t pc_v;
        addr_t next_pc;
        word_t acc_v;
        logic  done;
        int    steps;
        acc_v = '0;
        pc_v  = '0;
        done  = 1'b0;
        steps = 0;
        while (!done && steps < 4 * MAX_INSTR) begin
            ins = model_mem[pc_v];
            adr = ins[9:0];
            next_pc = pc_v + addr_t'(1);
            steps++;
            case (ins[15:14])
                2'd0: acc_v = alu_model(ins[13:10], acc_v, model_mem[adr]);
                2'd1: acc_v = model_mem[adr];
                2'd2: model_mem[adr] = acc_v;
                default: begin
                    // halt keeps pc on itself
                    if (ins[13:10] == 4'd2) begin
                        done = 1'b1;
                        next_pc = pc_v;
                    end else if (ins[13:10] == 4'd0 ||
                                 (ins[13:10] == 4'd1 && acc_v == '0)) begin
                        next_pc = adr;
                    end
                end
            endcase
            pc_v = next_pc;
        end
        if (!done) begin
            report_error("model ran a program that never reached a halt");
        end
        m_acc = acc_v;
        m_pc  = pc_v;
    endtask

    // pulse run and wait for halted while optionally reading over the host port
    task automatic run_program(input logic contend);
        addr_t a;
        word_t rd;
        run = 1'b1;
        @(posedge clk);
        #1;
        run = 1'b0;
        // first fetch already under way
        if (busy !== 1'b1) begin
            report_error("busy is low right after the run pulse");
        end
        while (!halted) begin
            if (contend) begin
                a = {1'b1, 9'(rand_below(512))};
                host_xfer(1'b0, a, '0, rd);
                check_word(rd, img[a], "host read during a run");
            end else begin
                @(posedge clk);
                #1;
            end
        end
        if (busy !== 1'b0) begin
            report_error("busy is still high at halt");
        end
    endtask

    initial begin
        int    i;
        int    t;
        word_t exp_acc;
        addr_t exp_pc;
        seed = 32'h52a8_5113;
        arst_n = 1'b0;
        run = 1'b0;
        host_req = '0;
        repeat (8) @(posedge clk);
        #1;
        arst_n = 1'b1;
        // state straight out of reset
        if (halted !== 1'b0 || busy !== 1'b0 || host_rsp.ack !== 1'b0) begin
            report_error("halted, busy or host ack is high after reset");
        end
        check_word(acc, '0, "acc after reset");
        check_addr(pc, '0, "pc after reset");
        // host write and read back of random words
        for (i = 0; i < MEM_WORDS; i++) begin
            img[i] = word_t'(next_rand() >> 16);
        end
        load_image();
        model_mem = img;
        readback_all();
        for (t = 0; t < N_TESTS; t++) begin
            build_program(t % 4);
            load_image();
            model_mem = img;
            run_model(exp_acc, exp_pc);
            run_program(t % 4 == 3);
            check_word(acc, exp_acc, "acc at halt");
            check_addr(pc, exp_pc, "pc at halt");
            readback_all();
        end
        if (error_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
logic/acc_cpu_pkg.sv
logic/alu.sv
logic/cpu_datapath.sv
logic/cpu_sequencer.sv
logic/main_memory.sv
logic/acc_cpu_top.sv
verification/acc_cpu_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the accumulator cpu testbench with verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module acc_cpu_tb -f filelist.f
./obj_dir/Vacc_cpu_tb | tee sim.log
if grep -q "Testbench passed" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi
